// ==== msg_pkg.sv ====
// core message format
package msg_pkg;

  // one message as raised by a core
  typedef logic [63:0] msg_data_t;

  // bit of the message that picks the destination port
  localparam int MSG_PORT_BIT = 16;

  // number of message ports
  localparam int PORT_COUNT = 2;

  // destination port index
  typedef logic [$clog2(PORT_COUNT)-1:0] msg_port_t;

endpackage

// ==== sys_pkg.sv ====
// system sizing
package sys_pkg;

  // processing cores feeding the message path
  localparam int CORE_COUNT = 16;

  // core number, as reported next to each message
  typedef logic [$clog2(CORE_COUNT)-1:0] core_no_t;

  // one bit per core
  typedef logic [CORE_COUNT-1:0] core_mask_t;

  // per-core fifo address width giving a depth of 2**width
  localparam int DEF_FIFO_ADDR_SIZE = 3;

endpackage

// ==== core_msg_fifo.sv ====
// per-core message fifo
`timescale 1ns/1ps

module core_msg_fifo #(
  parameter int CORE_FIFO_ADDR_SIZE = sys_pkg::DEF_FIFO_ADDR_SIZE
) (
  input  logic                logic_clk,
  input  logic                rst_n,

  input  msg_pkg::msg_data_t  wr_data,
  input  logic                wr_en,

  input  logic                rd_en,
  output msg_pkg::msg_data_t  rd_data,
  output logic                empty,

  output logic                drop
);

  import msg_pkg::*;

  localparam int DEPTH = 2 ** CORE_FIFO_ADDR_SIZE;

  typedef logic [CORE_FIFO_ADDR_SIZE-1:0] ptr_t;
  typedef logic [CORE_FIFO_ADDR_SIZE:0]   count_t;

  msg_data_t mem [DEPTH];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;

  logic full;
  logic do_wr;
  logic do_rd;

  assign full  = (count == count_t'(DEPTH));
  assign empty = (count == '0);

  // the core cannot be stalled, so a write into a full buffer is lost
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // head entry is always on the output
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge logic_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      drop   <= 1'b0;
    end else begin
      // one cycle pulse per lost message
      drop <= wr_en && full;

      if (do_wr) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end

      case ({do_wr, do_rd})
        2'b10:   count <= count + count_t'(1);
        2'b01:   count <= count - count_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rr_arbiter.sv ====
// round-robin grant among cores
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                  logic_clk,
  input  logic                  rst_n,

  input  sys_pkg::core_mask_t   req,
  input  logic                  accept,

  output logic                  grant_valid,
  output sys_pkg::core_no_t     grant_no
);

  import sys_pkg::*;

  // first core to look at on the next grant
  core_no_t ptr;

  // lowest requester at or after ptr, wrapping to core 0
  always_comb begin
    int idx;

    grant_valid = 1'b0;
    grant_no    = '0;

    for (int k = 0; k < CORE_COUNT; k++) begin
      idx = (int'(ptr) + k) % CORE_COUNT;
      if (req[idx] && !grant_valid) begin
        grant_valid = 1'b1;
        grant_no    = core_no_t'(idx);
      end
    end
  end

  // move past the served core
  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (accept && grant_valid) begin
      if (grant_no == core_no_t'(CORE_COUNT - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= grant_no + core_no_t'(1);
      end
    end
  end

endmodule

// ==== core_msg_arbiter.sv ====
// message arbiter for one port
`timescale 1ns/1ps

module core_msg_arbiter #(
  parameter msg_pkg::msg_port_t PORT_NO = '0,
  parameter int CORE_FIFO_ADDR_SIZE     = sys_pkg::DEF_FIFO_ADDR_SIZE
) (
  input  logic                  logic_clk,
  input  logic                  rst_n,

  // message strobes from all cores
  input  msg_pkg::msg_data_t    core_msg_data [sys_pkg::CORE_COUNT],
  input  sys_pkg::core_mask_t   core_msg_valid,

  // port side
  output msg_pkg::msg_data_t    msg_data,
  output sys_pkg::core_no_t     msg_core_no,
  output logic                  msg_valid,
  input  logic                  msg_ready,

  output sys_pkg::core_mask_t   msg_drop
);

  import msg_pkg::*;
  import sys_pkg::*;

  core_mask_t fifo_wr;
  core_mask_t fifo_rd;
  core_mask_t fifo_empty;
  msg_data_t  fifo_rd_data [CORE_COUNT];

  core_mask_t req;
  logic       grant_valid;
  core_no_t   grant_no;
  msg_data_t  head_data;

  logic out_free;
  logic pop;

  // output register can take a new message
  assign out_free = !msg_valid || msg_ready;
  assign pop      = out_free && grant_valid;

  assign req = ~fifo_empty;

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
    // keep only strobes addressed to this port
    assign fifo_wr[i] = core_msg_valid[i] &&
                        (core_msg_data[i][MSG_PORT_BIT] == PORT_NO);

    assign fifo_rd[i] = pop && (grant_no == core_no_t'(i));

    core_msg_fifo #(
      .CORE_FIFO_ADDR_SIZE(CORE_FIFO_ADDR_SIZE)
    ) core_fifo_i (
      .logic_clk (logic_clk),
      .rst_n     (rst_n),
      .wr_data   (core_msg_data[i]),
      .wr_en     (fifo_wr[i]),
      .rd_en     (fifo_rd[i]),
      .rd_data   (fifo_rd_data[i]),
      .empty     (fifo_empty[i]),
      .drop      (msg_drop[i])
    );
  end

  rr_arbiter rr_arbiter_i (
    .logic_clk   (logic_clk),
    .rst_n       (rst_n),
    .req         (req),
    .accept      (out_free),
    .grant_valid (grant_valid),
    .grant_no    (grant_no)
  );

  // head of the granted fifo
  assign head_data = fifo_rd_data[grant_no];

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      msg_valid <= 1'b0;
    end else if (out_free) begin
      msg_valid <= grant_valid;
    end
  end

  // payload and sender held until consumed
  always_ff @(posedge logic_clk) begin
    if (pop) begin
      msg_data    <= head_data;
      msg_core_no <= grant_no;
    end
  end

endmodule

// ==== core_msg_hub.sv ====
// core message hub
`timescale 1ns/1ps

module core_msg_hub #(
  parameter int CORE_FIFO_ADDR_SIZE = sys_pkg::DEF_FIFO_ADDR_SIZE
) (
  input  logic                                logic_clk,
  input  logic                                rst_n,

  // core message strobes
  input  msg_pkg::msg_data_t                  core_msg_data [sys_pkg::CORE_COUNT],
  input  sys_pkg::core_mask_t                 core_msg_valid,

  // one valid/ready consumer per port
  output msg_pkg::msg_data_t                  msg_data    [msg_pkg::PORT_COUNT],
  output sys_pkg::core_no_t                   msg_core_no [msg_pkg::PORT_COUNT],
  output logic [msg_pkg::PORT_COUNT-1:0]      msg_valid,
  input  logic [msg_pkg::PORT_COUNT-1:0]      msg_ready,

  // per-core drop pulses for each port
  output sys_pkg::core_mask_t                 msg_drop    [msg_pkg::PORT_COUNT]
);

  import msg_pkg::*;

  // every arbiter sees all cores and keeps its own port's messages
  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    core_msg_arbiter #(
      .PORT_NO             (msg_port_t'(p)),
      .CORE_FIFO_ADDR_SIZE (CORE_FIFO_ADDR_SIZE)
    ) msg_arbiter_i (
      .logic_clk      (logic_clk),
      .rst_n          (rst_n),

      .core_msg_data  (core_msg_data),
      .core_msg_valid (core_msg_valid),

      .msg_data       (msg_data[p]),
      .msg_core_no    (msg_core_no[p]),
      .msg_valid      (msg_valid[p]),
      .msg_ready      (msg_ready[p]),

      .msg_drop       (msg_drop[p])
    );
  end

endmodule

// ==== core_msg_hub_chk.sv ====
// message hub port checks
`timescale 1ns/1ps

module core_msg_hub_chk (
  input logic                            logic_clk,
  input logic                            rst_n,
  input msg_pkg::msg_data_t              msg_data    [msg_pkg::PORT_COUNT],
  input sys_pkg::core_no_t               msg_core_no [msg_pkg::PORT_COUNT],
  input logic [msg_pkg::PORT_COUNT-1:0]  msg_valid,
  input logic [msg_pkg::PORT_COUNT-1:0]  msg_ready,
  input sys_pkg::core_mask_t             msg_drop    [msg_pkg::PORT_COUNT]
);

  import msg_pkg::*;

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    // stalled message keeps payload and sender
    hold_a: assert property (@(posedge logic_clk) disable iff (!rst_n)
      msg_valid[p] && !msg_ready[p] |=>
        msg_valid[p] && $stable(msg_data[p]) && $stable(msg_core_no[p]))
      else $error("port %0d changed a stalled message", p);

    reset_a: assert property (@(posedge logic_clk)
      !rst_n |=> !msg_valid[p] && (msg_drop[p] == '0))
      else $error("port %0d not idle after reset", p);

    port_bit_a: assert property (@(posedge logic_clk) disable iff (!rst_n)
      msg_valid[p] |-> (msg_data[p][MSG_PORT_BIT] == msg_port_t'(p)))
      else $error("port %0d carries a message for the other port", p);
  end

endmodule

bind core_msg_hub core_msg_hub_chk core_msg_hub_chk_i (
  .logic_clk   (logic_clk),
  .rst_n       (rst_n),
  .msg_data    (msg_data),
  .msg_core_no (msg_core_no),
  .msg_valid   (msg_valid),
  .msg_ready   (msg_ready),
  .msg_drop    (msg_drop)
);

// ==== core_msg_hub_tb.sv ====
// message hub testbench
`timescale 1ns/1ps

module core_msg_hub_tb;

  import msg_pkg::*;
  import sys_pkg::*;

  localparam int FIFO_DEPTH     = 2 ** DEF_FIFO_ADDR_SIZE;
  localparam int QDEPTH         = 64;
  localparam int TIMEOUT_CYCLES = 3000;

  logic                  logic_clk;
  logic                  rst_n;
  msg_data_t             core_msg_data [CORE_COUNT];
  core_mask_t            core_msg_valid;
  msg_data_t             msg_data      [PORT_COUNT];
  core_no_t              msg_core_no   [PORT_COUNT];
  logic [PORT_COUNT-1:0] msg_valid;
  logic [PORT_COUNT-1:0] msg_ready;
  core_mask_t            msg_drop      [PORT_COUNT];

  // strobes for the next falling edge
  msg_data_t  stage_data [CORE_COUNT];
  core_mask_t stage_valid;

  // expected messages per port and core in ring buffers
  msg_data_t  exp_mem [PORT_COUNT][CORE_COUNT][QDEPTH];
  int         exp_wr  [PORT_COUNT][CORE_COUNT];
  int         exp_rd  [PORT_COUNT][CORE_COUNT];
  int         pending;

  core_no_t   order_q [$];
  core_mask_t drop_seen [PORT_COUNT];
  logic [31:0] rng;
  string      test_name;
  int         cycle_count;

  core_msg_hub #(
    .CORE_FIFO_ADDR_SIZE(DEF_FIFO_ADDR_SIZE)
  ) core_msg_hub_i (
    .logic_clk      (logic_clk),
    .rst_n          (rst_n),
    .core_msg_data  (core_msg_data),
    .core_msg_valid (core_msg_valid),
    .msg_data       (msg_data),
    .msg_core_no    (msg_core_no),
    .msg_valid      (msg_valid),
    .msg_ready      (msg_ready),
    .msg_drop       (msg_drop)
  );

  always #50 logic_clk = ~logic_clk;

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge logic_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_data(input msg_data_t exp, input msg_data_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected data %h, actual %h", test_name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_core(input core_no_t exp, input core_no_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected core %0d, actual %0d", test_name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_mask(input core_mask_t exp, input core_mask_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected drop %h, actual %h", test_name, exp, act);
      stop_run();
    end
  endtask

  function automatic int outstanding(input int p, input int c);
    return exp_wr[p][c] - exp_rd[p][c];
  endfunction

  task automatic new_payload(input logic port_sel, output msg_data_t m);
    rng = xorshift(rng);
    m[31:0] = rng;
    rng = xorshift(rng);
    m[63:32] = rng;
    m[MSG_PORT_BIT] = port_sel;
  endtask

  // stage a strobe; a message expected to be dropped is not queued
  task automatic queue_send(input core_no_t c, input msg_data_t m, input logic kept);
    int p;
    p = int'(m[MSG_PORT_BIT]);
    stage_data[c]  = m;
    stage_valid[c] = 1'b1;
    if (kept) begin
      exp_mem[p][c][exp_wr[p][c] % QDEPTH] = m;
      exp_wr[p][c]++;
      pending++;
    end
  endtask

  // transfer happens at the coming rising edge
  task automatic take_message(input int p);
    core_no_t  c;
    core_no_t  exp_core;
    msg_data_t exp;
    c = msg_core_no[p];
    if (order_q.size() > 0) begin
      exp_core = order_q.pop_front();
      check_core(exp_core, c);
    end
    if (outstanding(p, int'(c)) == 0) begin
      $display("%s: port %0d delivered a message from core %0d that was never sent",
               test_name, p, c);
      stop_run();
    end
    exp = exp_mem[p][c][exp_rd[p][c] % QDEPTH];
    check_data(exp, msg_data[p]);
    exp_rd[p][c]++;
    pending--;
  endtask

  task automatic cycle(input logic [PORT_COUNT-1:0] ready);
    @(negedge logic_clk);
    for (int p = 0; p < PORT_COUNT; p++) begin
      drop_seen[p] = drop_seen[p] | msg_drop[p];
    end
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_msg_data[c] = stage_data[c];
    end
    core_msg_valid = stage_valid;
    stage_valid    = '0;
    msg_ready      = ready;
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (msg_valid[p] && ready[p]) begin
        take_message(p);
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    rst_n = 1'b0;
    cycle('0);
    cycle('0);
    rst_n = 1'b1;
    for (int p = 0; p < PORT_COUNT; p++) begin
      drop_seen[p] = '0;
    end
  endtask

  task automatic wait_idle(input logic [PORT_COUNT-1:0] ready);
    while (pending != 0) begin
      cycle(ready);
    end
    // nothing extra may show up afterwards
    repeat (4) cycle(ready);
  endtask

  task automatic end_test(input core_mask_t exp_drop0, input core_mask_t exp_drop1);
    check_mask(exp_drop0, drop_seen[0]);
    check_mask(exp_drop1, drop_seen[1]);
  endtask

  task automatic test_single_route();
    msg_data_t m;
    start_test("single_route");
    for (int p = 0; p < PORT_COUNT; p++) begin
      new_payload(p[0], m);
      queue_send(core_no_t'(5), m, 1'b1);
      order_q.push_back(core_no_t'(5));
      cycle('1);
      wait_idle('1);
    end
    end_test('0, '0);
  endtask

  task automatic test_core_order();
    msg_data_t m;
    start_test("core_order");
    for (int k = 0; k < 6; k++) begin
      new_payload(k[0], m);
      queue_send(core_no_t'(3), m, 1'b1);
      cycle('1);
    end
    wait_idle('1);
    end_test('0, '0);
  endtask

  task automatic test_round_robin();
    msg_data_t m;
    core_no_t  rr_cores [4];
    rr_cores = '{4'd0, 4'd4, 4'd9, 4'd15};
    start_test("round_robin");
    for (int rep = 0; rep < 2; rep++) begin
      for (int k = 0; k < 4; k++) begin
        new_payload(1'b0, m);
        queue_send(rr_cores[k], m, 1'b1);
      end
      cycle(2'b10);
    end
    repeat (4) cycle(2'b10);
    // pointer starts at core 0 after reset
    for (int rep = 0; rep < 2; rep++) begin
      for (int k = 0; k < 4; k++) begin
        order_q.push_back(rr_cores[k]);
      end
    end
    wait_idle('1);
    if (order_q.size() != 0) begin
      $display("%s: %0d messages were never granted", test_name, order_q.size());
      stop_run();
    end
    end_test('0, '0);
  endtask

  task automatic test_back_pressure();
    msg_data_t m;
    start_test("back_pressure");
    // the output register and a full fifo take nine and the tenth is lost
    for (int k = 0; k < 10; k++) begin
      // no drop before the tenth strobe
      if (k == FIFO_DEPTH + 1) begin
        end_test('0, '0);
      end
      new_payload(1'b1, m);
      queue_send(core_no_t'(7), m, k < FIFO_DEPTH + 1);
      cycle(2'b01);
      cycle(2'b01);
    end
    repeat (2) cycle(2'b01);
    end_test('0, core_mask_t'(16'h0080));
    wait_idle('1);
    end_test('0, core_mask_t'(16'h0080));
  endtask

  task automatic test_random_traffic();
    logic [31:0] r;
    msg_data_t   m;
    core_no_t    c;
    logic        port_sel;
    start_test("random_traffic");
    for (int n = 0; n < 1000; n++) begin
      rng = xorshift(rng);
      r = rng;
      c = r[3:0];
      port_sel = r[4];
      // never let a fifo fill
      if (r[5] && outstanding(int'(port_sel), int'(c)) < FIFO_DEPTH) begin
        new_payload(port_sel, m);
        queue_send(c, m, 1'b1);
      end
      cycle(r[9:8]);
    end
    wait_idle('1);
    end_test('0, '0);
  endtask

  initial begin
    logic_clk      = 1'b0;
    rst_n          = 1'b0;
    core_msg_valid = '0;
    msg_ready      = '0;
    stage_valid    = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_msg_data[c] = '0;
      stage_data[c]    = '0;
    end
    pending     = 0;
    cycle_count = 0;
    rng         = 32'h468a;

    test_single_route();
    test_core_order();
    test_round_robin();
    test_back_pressure();
    test_random_traffic();

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== core_msg_hub.f ====
msg_pkg.sv
sys_pkg.sv
core_msg_fifo.sv
rr_arbiter.sv
core_msg_arbiter.sv
core_msg_hub.sv
core_msg_hub_chk.sv
core_msg_hub_tb.sv

// ==== Bender.yml ====
package:
  name: core_msg_hub

sources:
  - msg_pkg.sv
  - sys_pkg.sv
  - core_msg_fifo.sv
  - rr_arbiter.sv
  - core_msg_arbiter.sv
  - core_msg_hub.sv
  - target: test
    files:
      - core_msg_hub_chk.sv
      - core_msg_hub_tb.sv
